//--- source/vic_log_pkg.sv
package vic_log_pkg;

    // basic widths
    localparam int ADDR_W = 6;                        // video registers live on adl[5:0]
    localparam int DATA_W = 8;                        // cpu data bus and serial byte

    // phi generation, sys_clock stands in for the 4x dot clock
    localparam int PHI_DIV  = 32;                     // sys_clock cycles per phi cycle
    localparam int PHI_W    = $clog2(PHI_DIV);
    localparam int PHI_LAST = PHI_DIV - 1;            // bus sample point, end of phi high
    localparam int PHI_HALF = PHI_DIV / 2;            // phi goes high here

    // first byte of a pair is {marker, address}
    localparam logic [1:0] ADDR_MARKER = 2'd2;

    // byte buffer
    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_AW    = $clog2(FIFO_DEPTH);   // index bits, pointers add a wrap bit

    // serial side
    localparam int CLKS_PER_BIT = 8;                  // sys_clock cycles per 8N1 bit
    localparam int CCLK_STABLE  = 64;                 // high cycles of cclk before sending

    typedef logic [ADDR_W-1:0]                 reg_addr_t;
    typedef logic [DATA_W-1:0]                 bus_byte_t;
    typedef logic [PHI_W-1:0]                  phi_count_t;
    typedef logic [FIFO_AW:0]                  fifo_ptr_t;    // msb is the wrap bit
    typedef logic [$clog2(CLKS_PER_BIT)-1:0]   bit_time_t;
    typedef logic [$clog2(DATA_W)-1:0]         bit_idx_t;
    typedef logic [$clog2(CCLK_STABLE):0]      cclk_count_t;  // must reach CCLK_STABLE

    // transmitter frame sequencing
    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_t;

endpackage : vic_log_pkg

//--- source/reg_write_logger.sv
`timescale 1ns/10ps

module reg_write_logger import vic_log_pkg::*; (
    input  logic      sys_clock,
    input  logic      arst_n,
    input  logic      ce,            // chip enable, low = selected
    input  logic      rw,            // low = cpu write
    input  reg_addr_t adl,           // register address
    input  bus_byte_t dbl,           // data bus
    output logic      clk_phi,
    output logic      byte_strobe,   // one cycle per byte, no back-pressure
    output bus_byte_t byte_data
);

    phi_count_t phi_cnt;      // position inside the phi cycle
    logic       sample_now;   // last count of phi high
    logic       bus_write;    // sampled a cpu write this cycle
    logic       data_pend;    // data byte still to go out
    bus_byte_t  data_q;       // data held for the second strobe

    // phi divider, 0..31
    always_ff @(posedge sys_clock or negedge arst_n) begin
        if (!arst_n) begin
            phi_cnt <= '0;
        end else if (phi_cnt == phi_count_t'(PHI_LAST)) begin
            phi_cnt <= '0;
        end else begin
            phi_cnt <= phi_cnt + 1'b1;
        end
    end

    // low for 0..15, high for 16..31
    assign clk_phi = (phi_cnt >= phi_count_t'(PHI_HALF));

    // cpu bus is valid at the end of phi high
    assign sample_now = (phi_cnt == phi_count_t'(PHI_LAST));
    assign bus_write  = sample_now && !ce && !rw;

    // strobe sequencing
    // sample edge -> address byte next cycle -> data byte the cycle after
    always_ff @(posedge sys_clock or negedge arst_n) begin
        if (!arst_n) begin
            byte_strobe <= 1'b0;
            data_pend   <= 1'b0;
        end else begin
            byte_strobe <= bus_write || data_pend;
            data_pend   <= bus_write;        // only ever one cycle
        end
    end

    // byte payload
    always_ff @(posedge sys_clock) begin
        if (bus_write) begin
            byte_data <= {ADDR_MARKER, adl};  // marker tells address bytes from data
            data_q    <= dbl;
        end else if (data_pend) begin
            byte_data <= data_q;
        end
    end

    // a write is exactly one address and one data strobe, writes are 32 cycles apart
    a_strobe_max_two: assert property (
        @(posedge sys_clock) disable iff (!arst_n)
        (byte_strobe && $past(byte_strobe)) |-> !$past(byte_strobe, 2)
    );

endmodule : reg_write_logger

//--- source/tx_byte_fifo.sv
`timescale 1ns/10ps

module tx_byte_fifo import vic_log_pkg::*; (
    input  logic      sys_clock,
    input  logic      arst_n,
    input  logic      push,
    input  bus_byte_t push_data,
    input  logic      pop,
    output bus_byte_t head_data,   // oldest entry, valid while not empty
    output logic      empty,
    output logic      overflow     // sticky until reset
);

    bus_byte_t mem [FIFO_DEPTH];
    fifo_ptr_t wr_ptr;
    fifo_ptr_t rd_ptr;
    logic      full;
    logic      do_push;
    logic      do_pop;

    // same index, wrap bits differ -> full
    assign empty   = (wr_ptr == rd_ptr);
    assign full    = (wr_ptr[FIFO_AW-1:0] == rd_ptr[FIFO_AW-1:0]) &&
                     (wr_ptr[FIFO_AW] != rd_ptr[FIFO_AW]);
    assign do_push = push && !full;    // bytes arriving while full are lost
    assign do_pop  = pop && !empty;

    // storage
    always_ff @(posedge sys_clock) begin
        if (do_push) begin
            mem[wr_ptr[FIFO_AW-1:0]] <= push_data;
        end
    end

    assign head_data = mem[rd_ptr[FIFO_AW-1:0]];   // head moves the cycle after a pop

    // pointers
    always_ff @(posedge sys_clock or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // overflow latch
    always_ff @(posedge sys_clock or negedge arst_n) begin
        if (!arst_n) begin
            overflow <= 1'b0;
        end else if (push && full) begin
            overflow <= 1'b1;
        end
    end

    // the transmitter must only pop what has been pushed
    a_no_pop_empty: assert property (
        @(posedge sys_clock) disable iff (!arst_n)
        pop |-> !empty
    );

endmodule : tx_byte_fifo

//--- source/serial_tx.sv
`timescale 1ns/10ps

module serial_tx import vic_log_pkg::*; (
    input  logic      sys_clock,
    input  logic      arst_n,
    input  logic      cclk,         // high once the board mcu is configured
    input  bus_byte_t fifo_data,
    input  logic      fifo_empty,
    output logic      fifo_pop,     // one cycle pulse
    output logic      tx            // 8N1, idles high
);

    cclk_count_t cclk_cnt;    // consecutive high cycles, saturates
    logic        ready;
    tx_state_t   state;
    bit_time_t   bit_timer;   // cycles inside the current bit
    bit_idx_t    bit_idx;     // data bit being sent
    bus_byte_t   shift_q;     // remaining data bits, lsb goes next
    logic        bit_end;

    // cclk stability, any low cycle starts the count over
    always_ff @(posedge sys_clock or negedge arst_n) begin
        if (!arst_n) begin
            cclk_cnt <= '0;
        end else if (!cclk) begin
            cclk_cnt <= '0;
        end else if (cclk_cnt != cclk_count_t'(CCLK_STABLE)) begin
            cclk_cnt <= cclk_cnt + 1'b1;
        end
    end

    assign ready   = (cclk_cnt == cclk_count_t'(CCLK_STABLE));
    assign bit_end = (bit_timer == bit_time_t'(CLKS_PER_BIT - 1));

    // frame FSM, ready only gates the start of a frame
    always_ff @(posedge sys_clock or negedge arst_n) begin
        if (!arst_n) begin
            state     <= TX_IDLE;
            bit_timer <= '0;
            bit_idx   <= '0;
            fifo_pop  <= 1'b0;
            tx        <= 1'b1;
        end else begin
            fifo_pop <= 1'b0;
            if (state != TX_IDLE) begin
                bit_timer <= bit_timer + 1'b1;    // wraps to 0 at each bit end
            end
            case (state)
                TX_IDLE: begin
                    bit_timer <= '0;
                    if (ready && !fifo_empty) begin
                        fifo_pop <= 1'b1;
                        tx       <= 1'b0;         // start bit
                        state    <= TX_START;
                    end
                end
                TX_START: begin
                    if (bit_end) begin
                        tx      <= shift_q[0];
                        bit_idx <= '0;
                        state   <= TX_DATA;
                    end
                end
                TX_DATA: begin
                    if (bit_end) begin
                        if (bit_idx == bit_idx_t'(DATA_W - 1)) begin
                            tx    <= 1'b1;        // stop bit
                            state <= TX_STOP;
                        end else begin
                            tx      <= shift_q[1];
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end
                end
                TX_STOP: begin
                    if (bit_end) begin
                        state <= TX_IDLE;         // line stays high
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // data shifter
    always_ff @(posedge sys_clock) begin
        if (state == TX_IDLE && ready && !fifo_empty) begin
            shift_q <= fifo_data;                 // head is captured with the pop
        end else if (state == TX_DATA && bit_end) begin
            shift_q <= shift_q >> 1;
        end
    end

    // every frame ends with tx released high
    a_idle_high: assert property (
        @(posedge sys_clock) disable iff (!arst_n)
        (state == TX_IDLE) |-> tx
    );

endmodule : serial_tx

//--- source/vic_log_top.sv
`timescale 1ns/10ps

module vic_log_top import vic_log_pkg::*; (
    input  logic      sys_clock,   // 4x dot clock stand-in
    input  logic      arst_n,
    input  logic      ce,
    input  logic      rw,
    input  reg_addr_t adl,
    input  bus_byte_t dbl,
    input  logic      cclk,        // from board mcu
    output logic      clk_phi,     // cpu phi
    output logic      tx,          // debug serial out
    output logic      overflow     // debug bytes were lost
);

    logic      byte_strobe;
    bus_byte_t byte_data;
    bus_byte_t fifo_data;
    logic      fifo_empty;
    logic      fifo_pop;

    // producer
    reg_write_logger u_logger (
        .sys_clock   (sys_clock),
        .arst_n      (arst_n),
        .ce          (ce),
        .rw          (rw),
        .adl         (adl),
        .dbl         (dbl),
        .clk_phi     (clk_phi),
        .byte_strobe (byte_strobe),
        .byte_data   (byte_data)
    );

    // buffer
    tx_byte_fifo u_fifo (
        .sys_clock (sys_clock),
        .arst_n    (arst_n),
        .push      (byte_strobe),
        .push_data (byte_data),
        .pop       (fifo_pop),
        .head_data (fifo_data),
        .empty     (fifo_empty),
        .overflow  (overflow)
    );

    // consumer
    serial_tx u_tx (
        .sys_clock  (sys_clock),
        .arst_n     (arst_n),
        .cclk       (cclk),
        .fifo_data  (fifo_data),
        .fifo_empty (fifo_empty),
        .fifo_pop   (fifo_pop),
        .tx         (tx)
    );

endmodule : vic_log_top

//--- verif/vic_log_tb.sv
`timescale 1ns/10ps

module vic_log_tb import vic_log_pkg::*; ;

    localparam int CLK_PERIOD = 8;
    // about 150 bus cycles of 32 and 64 frames of 81 stay well below this
    localparam int MAX_CYCLES = 20000;

    logic      sys_clock;
    logic      arst_n;
    logic      ce;
    logic      rw;
    reg_addr_t adl;
    bus_byte_t dbl;
    logic      cclk;
    logic      clk_phi;
    logic      tx;
    logic      overflow;

    int        seed = 96364;
    int        errors;
    int        checks;
    int        cycles;
    int        frames;       // frames seen by the uart model
    int        held;         // bytes the fifo holds while cclk is low
    int        dropped;      // bytes the reference expects to be lost
    int        mark;
    int        wait_cnt;
    bit        blocked;      // set while cclk is low and nothing drains
    bit        timed_out;
    time       t_rise0;
    time       t_fall;
    time       t_rise1;
    bus_byte_t exp_q[$];
    bus_byte_t rx_q[$];
    bus_byte_t rx_byte;
    bus_byte_t got;

    vic_log_top dut (
        .sys_clock (sys_clock),
        .arst_n    (arst_n),
        .ce        (ce),
        .rw        (rw),
        .adl       (adl),
        .dbl       (dbl),
        .cclk      (cclk),
        .clk_phi   (clk_phi),
        .tx        (tx),
        .overflow  (overflow)
    );

    always #(CLK_PERIOD / 2) sys_clock = ~sys_clock;

    // expected pair for one write is {marker, address} then the data byte
    function automatic logic [15:0] write_bytes(input reg_addr_t a, input bus_byte_t d);
        return {ADDR_MARKER, a, d};
    endfunction

    task automatic check_value(input string what, input int value, input int want);
        checks++;
        assert (value == want) else begin
            errors++;
            $display("[ERROR] %0t ns: %s is %0h, expected %0h", $time, what, value, want);
        end
    endtask

    // only a fifo that cannot drain loses bytes
    task automatic expect_byte(input bus_byte_t b);
        if (!blocked) begin
            exp_q.push_back(b);
        end else if (held < FIFO_DEPTH) begin
            exp_q.push_back(b);
            held++;
        end else begin
            dropped++;
        end
    endtask

    // bus is held for one whole phi cycle and changes on phi rising
    task automatic bus_cycle(input logic c, input logic r, input reg_addr_t a, input bus_byte_t d);
        @(posedge clk_phi);
        ce  <= c;
        rw  <= r;
        adl <= a;
        dbl <= d;
    endtask

    task automatic cpu_write(input reg_addr_t a, input bus_byte_t d);
        logic [15:0] pair;
        pair = write_bytes(a, d);
        expect_byte(pair[15:8]);
        expect_byte(pair[7:0]);
        bus_cycle(1'b0, 1'b0, a, d);
    endtask

    task automatic random_write();
        cpu_write(reg_addr_t'($random(seed)), bus_byte_t'($random(seed)));
    endtask

    // either chip not selected or a cpu read
    task automatic idle_cycle();
        if ($random(seed) & 1) begin
            bus_cycle(1'b1, 1'(($random(seed))), reg_addr_t'($random(seed)),
                      bus_byte_t'($random(seed)));
        end else begin
            bus_cycle(1'b0, 1'b1, reg_addr_t'($random(seed)), bus_byte_t'($random(seed)));
        end
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            @(posedge sys_clock);
        end
        repeat (200) @(posedge sys_clock);   // room for stray frames
        held = 0;
    endtask

    task automatic finish_run();
        $display("checks %0d, errors %0d, dropped %0d, timeout %0d",
                 checks, errors, dropped, timed_out);
        if (errors == 0 && !timed_out) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    endtask

    // uart receiver sampling at mid-bit
    always begin
        @(negedge tx);
        repeat (CLKS_PER_BIT / 2) @(posedge sys_clock);
        check_value("start bit", int'(tx), 0);
        for (int i = 0; i < DATA_W; i++) begin
            repeat (CLKS_PER_BIT) @(posedge sys_clock);
            rx_byte[i] = tx;                     // lsb first
        end
        repeat (CLKS_PER_BIT) @(posedge sys_clock);
        check_value("stop bit", int'(tx), 1);
        rx_q.push_back(rx_byte);
        frames++;
    end

    // compare received bytes against the reference order
    always @(posedge sys_clock) begin
        if (rx_q.size() > 0) begin
            got = rx_q.pop_front();
            checks++;
            assert (exp_q.size() > 0) else begin
                errors++;
                $display("received byte %0h at %0t ns while no byte was expected", got, $time);
            end
            if (exp_q.size() > 0) begin
                check_value("tx byte", int'(got), int'(exp_q.pop_front()));
            end
        end
    end

    // watchdog
    always @(posedge sys_clock) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            timed_out = 1'b1;
            finish_run();
        end
    end

    initial begin
        sys_clock = 1'b0;
        arst_n    = 1'b0;
        ce        = 1'b1;
        rw        = 1'b1;
        adl       = '0;
        dbl       = '0;
        cclk      = 1'b0;
        blocked   = 1'b1;
        repeat (5) @(posedge sys_clock);
        arst_n <= 1'b1;
        check_value("tx after reset", int'(tx), 1);
        check_value("overflow after reset", int'(overflow), 0);

        // phi shape measured rise to rise
        @(posedge clk_phi);
        t_rise0 = $time;
        @(negedge clk_phi);
        t_fall = $time;
        @(posedge clk_phi);
        t_rise1 = $time;
        check_value("phi period", int'((t_rise1 - t_rise0) / CLK_PERIOD), PHI_DIV);
        check_value("phi high time", int'((t_fall - t_rise0) / CLK_PERIOD), PHI_DIV / 2);

        // random writes with cclk high are spaced so the link keeps up
        @(posedge sys_clock);
        cclk    <= 1'b1;
        blocked  = 1'b0;
        for (int n = 0; n < 20; n++) begin
            random_write();
            repeat (5) idle_cycle();
        end
        wait_drain();

        // reads and deselected cycles must stay silent
        mark = frames;
        repeat (10) idle_cycle();
        repeat (200) @(posedge sys_clock);
        check_value("frames during idle bus", frames, mark);

        // bytes buffer while cclk is low and go out once cclk is stable
        @(posedge sys_clock);
        cclk    <= 1'b0;
        blocked  = 1'b1;
        mark     = frames;
        repeat (4) random_write();
        idle_cycle();
        repeat (100) @(posedge sys_clock);
        check_value("frames with cclk low", frames, mark);
        check_value("tx with cclk low", int'(tx), 1);
        @(posedge sys_clock);
        cclk     <= 1'b1;
        wait_cnt  = 0;
        do begin
            @(posedge sys_clock);
            wait_cnt++;
        end while (tx !== 1'b0 && wait_cnt < 200);
        checks++;
        assert (wait_cnt >= CCLK_STABLE && tx === 1'b0) else begin
            errors++;
            $display("[ERROR] %0t ns: first start bit %0d cycles after cclk rose", $time, wait_cnt);
        end
        blocked = 1'b0;
        wait_drain();
        check_value("overflow before fill", int'(overflow), 0);

        // 20 bytes into 16 entries lose the last 4
        @(posedge sys_clock);
        cclk    <= 1'b0;
        blocked  = 1'b1;
        mark     = frames;
        repeat (10) random_write();
        idle_cycle();
        check_value("overflow after fill", int'(overflow), 1);
        @(posedge sys_clock);
        cclk    <= 1'b1;
        blocked  = 1'b0;
        wait_drain();
        check_value("frames after overflow", frames - mark, FIFO_DEPTH);

        finish_run();
    end

endmodule : vic_log_tb

//--- flist.f
source/vic_log_pkg.sv
source/reg_write_logger.sv
source/tx_byte_fifo.sv
source/serial_tx.sv
source/vic_log_top.sv
verif/vic_log_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the vic log testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f flist.f \
    --top-module vic_log_tb \
    -o vic_log_sim

./obj_dir/vic_log_sim | tee sim.log

if grep -q "Test OK" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi
